/* hdl/axis_rate_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface axis_rate_if;
    import flight_pkg::*;

    // Roll or yaw rate
    rate_t rate_a;
    // Pitch rate, zero on the yaw link
    rate_t rate_b;
    // One-cycle strobe, costs one credit
    logic  valid;
    // One-cycle pulse, gives one credit back
    logic  credit_return;

    // Control branch side
    modport sender (
        output rate_a,
        output rate_b,
        output valid,
        input  credit_return
    );

    // Mixer side
    modport receiver (
        input  rate_a,
        input  rate_b,
        input  valid,
        output credit_return
    );

endinterface

`default_nettype wire

/* hdl/esc_pulse_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module esc_pulse_generator #(
    parameter int CLKS_PER_US = 38,
    parameter int FRAME_US    = 2500
) (
    input  wire                            sys_clk,
    input  wire                            resetn,
    input  wire flight_pkg::motor_rate_t   motor_1_rate,
    input  wire flight_pkg::motor_rate_t   motor_2_rate,
    input  wire flight_pkg::motor_rate_t   motor_3_rate,
    input  wire flight_pkg::motor_rate_t   motor_4_rate,
    output logic                           frame_start,
    output logic                           motor_1_pwm,
    output logic                           motor_2_pwm,
    output logic                           motor_3_pwm,
    output logic                           motor_4_pwm
);
    import flight_pkg::*;

    localparam int PRESC_W = $clog2(CLKS_PER_US + 1);
    // Covers both the frame position and the longest pulse
    localparam int POS_W   = $clog2(FRAME_US + ESC_MIN_US + 4 * MOTOR_MAX);

    logic [PRESC_W-1:0] presc;
    logic               us_tick;
    logic [POS_W-1:0]   frame_pos;
    logic               frame_end;
    motor_rate_t        rate_in [4];
    logic [POS_W-1:0]   width_us [4];

    // 1000 us plus 4 us per rate step
    function automatic logic [POS_W-1:0] pulse_us(input motor_rate_t r);
        return POS_W'(ESC_MIN_US) + POS_W'({r, 2'b00});
    endfunction

    assign rate_in[0] = motor_1_rate;
    assign rate_in[1] = motor_2_rate;
    assign rate_in[2] = motor_3_rate;
    assign rate_in[3] = motor_4_rate;

    assign us_tick   = (presc == PRESC_W'(CLKS_PER_US - 1));
    assign frame_end = us_tick && (frame_pos == POS_W'(FRAME_US - 1));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            presc       <= '0;
            frame_pos   <= '0;
            frame_start <= 1'b0;
            // Zero width keeps every output low until the first frame
            for (int m = 0; m < 4; m++) begin
                width_us[m] <= '0;
            end
        end else begin
            presc       <= us_tick ? '0 : presc + 1'b1;
            frame_start <= frame_end;
            if (us_tick) begin
                frame_pos <= frame_end ? '0 : frame_pos + 1'b1;
            end
            // Snapshot taken as the new frame begins
            if (frame_end) begin
                for (int m = 0; m < 4; m++) begin
                    width_us[m] <= pulse_us(rate_in[m]);
                end
            end
        end
    end

    // High from frame start until the latched width
    assign motor_1_pwm = (frame_pos < width_us[0]);
    assign motor_2_pwm = (frame_pos < width_us[1]);
    assign motor_3_pwm = (frame_pos < width_us[2]);
    assign motor_4_pwm = (frame_pos < width_us[3]);

endmodule

`default_nettype wire

/* hdl/flight_core.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_core #(
    parameter int CLKS_PER_US  = 38,
    parameter int KP_SHIFT     = 2,
    parameter int YAW_DEADBAND = 8,
    parameter int FRAME_US     = 2500,
    parameter int QUEUE_DEPTH  = 2
) (
    input  wire                           sys_clk,
    input  wire                           resetn,
    input  wire                           throttle_pwm,
    input  wire                           roll_pwm,
    input  wire                           pitch_pwm,
    input  wire                           yaw_pwm,
    input  wire                           imu_valid,
    input  wire flight_pkg::imu_angle_t   imu_roll,
    input  wire flight_pkg::imu_angle_t   imu_pitch,
    input  wire flight_pkg::imu_angle_t   imu_heading,
    output logic                          motor_1_pwm,
    output logic                          motor_2_pwm,
    output logic                          motor_3_pwm,
    output logic                          motor_4_pwm,
    output logic                          imu_overrun
);
    import flight_pkg::*;

    // Decoded sticks
    rc_val_t     throttle_val;
    rc_val_t     roll_val;
    rc_val_t     pitch_val;
    rc_val_t     yaw_val;

    // Mixer to ESC generator
    motor_rate_t motor_1_rate;
    motor_rate_t motor_2_rate;
    motor_rate_t motor_3_rate;
    motor_rate_t motor_4_rate;
    logic        frame_start;

    // Roll and pitch link, yaw link
    axis_rate_if tilt_bus ();
    axis_rate_if yaw_bus ();

    rc_pulse_decoder #(.CLKS_PER_US(CLKS_PER_US)) u_throttle_rx (
        .sys_clk(sys_clk), .resetn(resetn), .pulse_in(throttle_pwm), .value(throttle_val));

    rc_pulse_decoder #(.CLKS_PER_US(CLKS_PER_US)) u_roll_rx (
        .sys_clk(sys_clk), .resetn(resetn), .pulse_in(roll_pwm), .value(roll_val));

    rc_pulse_decoder #(.CLKS_PER_US(CLKS_PER_US)) u_pitch_rx (
        .sys_clk(sys_clk), .resetn(resetn), .pulse_in(pitch_pwm), .value(pitch_val));

    rc_pulse_decoder #(.CLKS_PER_US(CLKS_PER_US)) u_yaw_rx (
        .sys_clk(sys_clk), .resetn(resetn), .pulse_in(yaw_pwm), .value(yaw_val));

    // Both branches see every IMU strobe
    tilt_controller #(
        .KP_SHIFT(KP_SHIFT),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_tilt (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .imu_valid(imu_valid),
        .roll_stick(roll_val),
        .pitch_stick(pitch_val),
        .imu_roll(imu_roll),
        .imu_pitch(imu_pitch),
        .overrun(imu_overrun),
        .out_bus(tilt_bus)
    );

    yaw_controller #(
        .KP_SHIFT(KP_SHIFT),
        .YAW_DEADBAND(YAW_DEADBAND),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_yaw (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .imu_valid(imu_valid),
        .yaw_stick(yaw_val),
        .imu_heading(imu_heading),
        .out_bus(yaw_bus)
    );

    motor_mixer #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_mixer (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .frame_start(frame_start),
        .throttle(throttle_val),
        .tilt_bus(tilt_bus),
        .yaw_bus(yaw_bus),
        .motor_1_rate(motor_1_rate),
        .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate),
        .motor_4_rate(motor_4_rate)
    );

    esc_pulse_generator #(
        .CLKS_PER_US(CLKS_PER_US),
        .FRAME_US(FRAME_US)
    ) u_esc (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .motor_1_rate(motor_1_rate),
        .motor_2_rate(motor_2_rate),
        .motor_3_rate(motor_3_rate),
        .motor_4_rate(motor_4_rate),
        .frame_start(frame_start),
        .motor_1_pwm(motor_1_pwm),
        .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm),
        .motor_4_pwm(motor_4_pwm)
    );

endmodule

`default_nettype wire

/* hdl/flight_pkg.sv */
`default_nettype none

package flight_pkg;

    // Decoded receiver stick, 0 to 250
    typedef logic [7:0] rc_val_t;

    // IMU Euler angle, wraps at 16 bits
    typedef logic signed [15:0] imu_angle_t;

    // Correction rate out of a control branch
    typedef logic signed [15:0] rate_t;

    // Motor command toward the ESC, 0 to 250
    typedef logic [7:0] motor_rate_t;

    // Free queue slots seen by a branch
    typedef logic [1:0] credit_t;

    // Receiver pulse width for stick value 0
    localparam int RC_MIN_US = 1000;
    // Stick range and neutral point
    localparam int STICK_MAX = 250;
    localparam int STICK_CENTER = 125;

    // Motor saturation and arming level
    localparam int MOTOR_MAX = 250;
    localparam int ARM_THRESHOLD = 10;

    // ESC pulse width at motor rate 0
    localparam int ESC_MIN_US = 1000;

    typedef enum logic {
        YAW_UNLOCKED,
        YAW_TRACKING
    } yaw_state_e;

endpackage

`default_nettype wire

/* hdl/motor_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_mixer #(
    parameter int QUEUE_DEPTH = 2
) (
    input  wire                        sys_clk,
    input  wire                        resetn,
    input  wire                        frame_start,
    input  wire flight_pkg::rc_val_t   throttle,
    axis_rate_if.receiver              tilt_bus,
    axis_rate_if.receiver              yaw_bus,
    output flight_pkg::motor_rate_t    motor_1_rate,
    output flight_pkg::motor_rate_t    motor_2_rate,
    output flight_pkg::motor_rate_t    motor_3_rate,
    output flight_pkg::motor_rate_t    motor_4_rate
);
    import flight_pkg::*;

    localparam int RW    = $bits(rate_t);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Queue entry holds both lanes of a bus
    typedef logic [2*RW-1:0] entry_t;
    // Wide enough for throttle plus three full-range rates
    typedef logic signed [RW+1:0] sum_t;

    // Index 0 is the tilt queue, 1 the yaw queue
    entry_t           q_mem [2][QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr [2];
    logic [PTR_W-1:0] rd_ptr [2];
    logic [CNT_W-1:0] count [2];
    logic             push [2];
    entry_t           push_data [2];
    entry_t           head [2];
    logic             pop;
    logic             armed;
    logic             credit_pulse;
    sum_t             t_s;
    sum_t             r_s;
    sum_t             p_s;
    sum_t             y_s;
    sum_t             sum [4];
    motor_rate_t      rate_q [4];

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic motor_rate_t clamp_rate(input sum_t s);
        if (s < 0) begin
            return '0;
        end
        if (s > sum_t'(MOTOR_MAX)) begin
            return motor_rate_t'(MOTOR_MAX);
        end
        return s[7:0];
    endfunction

    assign push[0]      = tilt_bus.valid;
    assign push[1]      = yaw_bus.valid;
    assign push_data[0] = {tilt_bus.rate_a, tilt_bus.rate_b};
    assign push_data[1] = {yaw_bus.rate_a, yaw_bus.rate_b};
    assign head[0]      = q_mem[0][rd_ptr[0]];
    assign head[1]      = q_mem[1][rd_ptr[1]];

    // Consume only on a frame boundary and only with both results queued
    assign pop = frame_start && (count[0] != '0) && (count[1] != '0);

    // Operands sign-extended to the sum width
    assign t_s = sum_t'(throttle);
    assign r_s = sum_t'(signed'(head[0][2*RW-1:RW]));
    assign p_s = sum_t'(signed'(head[0][RW-1:0]));
    assign y_s = sum_t'(signed'(head[1][2*RW-1:RW]));

    // X-quad mix
    assign sum[0] = t_s + p_s + r_s - y_s;
    assign sum[1] = t_s + p_s - r_s + y_s;
    assign sum[2] = t_s - p_s - r_s - y_s;
    assign sum[3] = t_s - p_s + r_s + y_s;

    assign armed = (throttle >= rc_val_t'(ARM_THRESHOLD));

    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < 2; i++) begin
            if (push[i]) begin
                q_mem[i][wr_ptr[i]] <= push_data[i];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            for (int i = 0; i < 2; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
            for (int m = 0; m < 4; m++) begin
                rate_q[m] <= '0;
            end
            credit_pulse <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (push[i]) begin
                    wr_ptr[i] <= ptr_inc(wr_ptr[i]);
                end
                if (pop) begin
                    rd_ptr[i] <= ptr_inc(rd_ptr[i]);
                end
                if (push[i] && !pop) begin
                    count[i] <= count[i] + 1'b1;
                end else if (!push[i] && pop) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
            // Credit goes back alongside the new rates
            credit_pulse <= pop;
            if (pop) begin
                for (int m = 0; m < 4; m++) begin
                    rate_q[m] <= armed ? clamp_rate(sum[m]) : '0;
                end
            end
        end
    end

    assign tilt_bus.credit_return = credit_pulse;
    assign yaw_bus.credit_return  = credit_pulse;

    assign motor_1_rate = rate_q[0];
    assign motor_2_rate = rate_q[1];
    assign motor_3_rate = rate_q[2];
    assign motor_4_rate = rate_q[3];

    // Branch credit accounting keeps both queues from overflowing
    for (genvar g = 0; g < 2; g++) begin : g_queue_chk
        a_no_overflow: assert property (@(posedge sys_clk) disable iff (!resetn)
            push[g] |-> count[g] < CNT_W'(QUEUE_DEPTH));
    end

endmodule

`default_nettype wire

/* hdl/rc_pulse_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rc_pulse_decoder #(
    parameter int CLKS_PER_US = 38
) (
    input  wire                  sys_clk,
    input  wire                  resetn,
    input  wire                  pulse_in,
    output flight_pkg::rc_val_t  value
);
    import flight_pkg::*;

    // Room for about 4 ms of high time
    localparam int WIDTH_W = 12;
    localparam int PRESC_W = $clog2(CLKS_PER_US + 1);

    logic [PRESC_W-1:0] presc;
    logic               us_tick;
    logic [WIDTH_W-1:0] width_us;
    logic [WIDTH_W-1:0] span;
    logic               pulse_d;
    logic               fall;
    rc_val_t            scaled;

    // Prescaler restarts with each pulse so the count lines up with the rising edge
    assign us_tick = pulse_in && (presc == PRESC_W'(CLKS_PER_US - 1));
    assign fall    = pulse_d && !pulse_in;

    // Offset from 1000 us, quarter scale, clamped to stick range
    assign span = (width_us - WIDTH_W'(RC_MIN_US)) >> 2;

    always_comb begin
        if (width_us <= WIDTH_W'(RC_MIN_US)) begin
            scaled = '0;
        end else if (span > WIDTH_W'(STICK_MAX)) begin
            scaled = rc_val_t'(STICK_MAX);
        end else begin
            scaled = span[7:0];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            presc    <= '0;
            width_us <= '0;
            pulse_d  <= 1'b0;
            value    <= '0;
        end else begin
            pulse_d <= pulse_in;
            if (!pulse_in) begin
                presc <= '0;
            end else if (presc == PRESC_W'(CLKS_PER_US - 1)) begin
                presc <= '0;
            end else begin
                presc <= presc + 1'b1;
            end
            // Width clears while low, holds at all ones on a stuck input
            if (!pulse_in) begin
                width_us <= '0;
            end else if (us_tick && (width_us != '1)) begin
                width_us <= width_us + 1'b1;
            end
            // New value only after a complete pulse
            if (fall) begin
                value <= scaled;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/tilt_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module tilt_controller #(
    parameter int KP_SHIFT    = 2,
    parameter int QUEUE_DEPTH = 2
) (
    input  wire                     sys_clk,
    input  wire                     resetn,
    input  wire                     imu_valid,
    input  wire flight_pkg::rc_val_t     roll_stick,
    input  wire flight_pkg::rc_val_t     pitch_stick,
    input  wire flight_pkg::imu_angle_t  imu_roll,
    input  wire flight_pkg::imu_angle_t  imu_pitch,
    output logic                    overrun,
    axis_rate_if.sender             out_bus
);
    import flight_pkg::*;

    rate_t   roll_target;
    rate_t   pitch_target;
    rate_t   roll_err;
    rate_t   pitch_err;
    credit_t credit;
    logic    accept;

    // Target angle is the stick offset from center, times 4
    assign roll_target  = (rate_t'(roll_stick) - rate_t'(STICK_CENTER)) <<< 2;
    assign pitch_target = (rate_t'(pitch_stick) - rate_t'(STICK_CENTER)) <<< 2;

    // Angle error, wraps like the IMU angles
    assign roll_err  = roll_target - imu_roll;
    assign pitch_err = pitch_target - imu_pitch;

    // Sample goes out only with a free mixer slot
    assign accept = imu_valid && (credit != '0);

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            credit        <= credit_t'(QUEUE_DEPTH);
            out_bus.valid <= 1'b0;
            overrun       <= 1'b0;
        end else begin
            credit        <= credit - credit_t'(accept) + credit_t'(out_bus.credit_return);
            out_bus.valid <= accept;
            // Dropped sample
            overrun       <= imu_valid && !accept;
        end
    end

    // Proportional term by arithmetic shift
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            out_bus.rate_a <= roll_err >>> KP_SHIFT;
            out_bus.rate_b <= pitch_err >>> KP_SHIFT;
        end
    end

    // Mixer returns no more than it was given
    a_credit_bound: assert property (@(posedge sys_clk) disable iff (!resetn)
        credit <= QUEUE_DEPTH);

    // A returned credit always matches one already spent
    a_return_owed: assert property (@(posedge sys_clk) disable iff (!resetn)
        out_bus.credit_return |-> credit < credit_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* hdl/yaw_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module yaw_controller #(
    parameter int KP_SHIFT     = 2,
    parameter int YAW_DEADBAND = 8,
    parameter int QUEUE_DEPTH  = 2
) (
    input  wire                     sys_clk,
    input  wire                     resetn,
    input  wire                     imu_valid,
    input  wire flight_pkg::rc_val_t     yaw_stick,
    input  wire flight_pkg::imu_angle_t  imu_heading,
    axis_rate_if.sender             out_bus
);
    import flight_pkg::*;

    yaw_state_e state;
    imu_angle_t heading_target;
    imu_angle_t target_next;
    imu_angle_t heading_err;
    rate_t      stick_off;
    logic       outside;
    credit_t    credit;
    logic       accept;

    // Signed stick offset and neutral window
    assign stick_off = rate_t'(yaw_stick) - rate_t'(STICK_CENTER);
    assign outside   = (stick_off > YAW_DEADBAND) || (stick_off < -YAW_DEADBAND);

    assign accept = imu_valid && (credit != '0);

    // First sample locks onto the current heading
    always_comb begin
        target_next = heading_target;
        if (state == YAW_UNLOCKED) begin
            target_next = imu_heading;
        end else if (outside) begin
            // Heading target drifts with the stick, wraps at 16 bits
            target_next = heading_target + stick_off;
        end
    end

    // Error against the updated target
    assign heading_err = target_next - imu_heading;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            state          <= YAW_UNLOCKED;
            heading_target <= '0;
            credit         <= credit_t'(QUEUE_DEPTH);
            out_bus.valid  <= 1'b0;
        end else begin
            credit        <= credit - credit_t'(accept) + credit_t'(out_bus.credit_return);
            out_bus.valid <= accept;
            if (accept) begin
                heading_target <= target_next;
                state          <= YAW_TRACKING;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            out_bus.rate_a <= heading_err >>> KP_SHIFT;
        end
    end

    // Second lane unused on this link
    assign out_bus.rate_b = '0;

    a_credit_bound: assert property (@(posedge sys_clk) disable iff (!resetn)
        credit <= QUEUE_DEPTH);

    a_return_owed: assert property (@(posedge sys_clk) disable iff (!resetn)
        out_bus.credit_return |-> credit < credit_t'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the flight core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_flight_core

./obj_dir/Vtb_flight_core | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi

/* sources.f */
hdl/flight_pkg.sv
hdl/axis_rate_if.sv
hdl/rc_pulse_decoder.sv
hdl/tilt_controller.sv
hdl/yaw_controller.sv
hdl/motor_mixer.sv
hdl/esc_pulse_generator.sv
hdl/flight_core.sv
tests/tb_flight_core.sv

/* tests/tb_flight_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_flight_core;
    import flight_pkg::*;

    localparam int CLKS_PER_US  = 1;
    localparam int KP_SHIFT     = 2;
    localparam int YAW_DEADBAND = 8;
    localparam int FRAME_US     = 2500;
    localparam int QUEUE_DEPTH  = 2;
    // Receiver frame, one microsecond per clock here
    localparam int RC_PERIOD    = 3000;
    localparam int SEED         = 63;

    logic        sys_clk = 1'b0;
    logic        resetn = 1'b0;
    logic [3:0]  rc_pwm = '0;
    logic        imu_valid = 1'b0;
    imu_angle_t  imu_roll = '0;
    imu_angle_t  imu_pitch = '0;
    imu_angle_t  imu_heading = '0;
    logic [3:0]  motor_pwm;
    logic        imu_overrun;

    // Receiver stimulus state, index 0 throttle, 1 roll, 2 pitch, 3 yaw
    int rc_width [4] = '{default: 0};
    int rc_model [4] = '{default: 0};
    int rc_phase;
    int rc_periods;

    // Pulse monitor
    int         cyc;
    int         frame_seen;
    logic [3:0] pwm_prev;
    logic [3:0] width_done;
    int         high_cnt [4];
    int         meas [4];
    int         pulse_cnt [4];

    // Reference model state
    int                 q_roll [$];
    int                 q_pitch [$];
    int                 q_yaw [$];
    int                 credit;
    logic               yaw_locked;
    logic signed [15:0] yaw_target;
    int                 model_rate [4];
    int                 exp_width [4];
    logic               exp_overrun;

    int mismatches = 0;
    int failures = 0;

    flight_core #(
        .CLKS_PER_US(CLKS_PER_US),
        .KP_SHIFT(KP_SHIFT),
        .FRAME_US(FRAME_US)
    ) UUT (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .throttle_pwm(rc_pwm[0]),
        .roll_pwm(rc_pwm[1]),
        .pitch_pwm(rc_pwm[2]),
        .yaw_pwm(rc_pwm[3]),
        .imu_valid(imu_valid),
        .imu_roll(imu_roll),
        .imu_pitch(imu_pitch),
        .imu_heading(imu_heading),
        .motor_1_pwm(motor_pwm[0]),
        .motor_2_pwm(motor_pwm[1]),
        .motor_3_pwm(motor_pwm[2]),
        .motor_4_pwm(motor_pwm[3]),
        .imu_overrun(imu_overrun)
    );

    initial begin
        forever #10 sys_clk = ~sys_clk;
    end

    // Receiver decode rule: offset from 1000 us, quarter scale, clamped
    function automatic int rc_decode(input int width_us);
        if (width_us <= RC_MIN_US) begin
            return 0;
        end
        if (((width_us - RC_MIN_US) >> 2) > STICK_MAX) begin
            return STICK_MAX;
        end
        return (width_us - RC_MIN_US) >> 2;
    endfunction

    // Stick target times 4 minus angle, 16-bit wrap, then gain shift
    function automatic int tilt_rate(input int stick, input int angle);
        logic signed [15:0] err;
        err = 16'((stick - STICK_CENTER) * 4 - angle);
        return int'(err >>> KP_SHIFT);
    endfunction

    function automatic int mix_clamp(input int thr, input int sum);
        if (thr < ARM_THRESHOLD || sum < 0) begin
            return 0;
        end
        return (sum > MOTOR_MAX) ? MOTOR_MAX : sum;
    endfunction

    function automatic int rand_angle(input int span);
        return int'($urandom_range(2 * span)) - span;
    endfunction

    // All channels start together, each falls at its own width
    always @(posedge sys_clk) begin
        if (!resetn) begin
            rc_phase   <= 0;
            rc_periods <= 0;
            rc_pwm     <= '0;
        end else begin
            for (int ch = 0; ch < 4; ch++) begin
                rc_pwm[ch] <= (rc_phase < rc_width[ch]);
            end
            if (rc_phase == RC_PERIOD - 1) begin
                rc_phase   <= 0;
                rc_periods <= rc_periods + 1;
            end else begin
                rc_phase <= rc_phase + 1;
            end
        end
    end

    // High time per motor, a rise on motor 1 marks a frame
    always @(posedge sys_clk) begin
        if (!resetn) begin
            cyc        <= 0;
            frame_seen <= 0;
            pwm_prev   <= '0;
            width_done <= '0;
            for (int m = 0; m < 4; m++) begin
                high_cnt[m]  <= 0;
                meas[m]      <= 0;
                pulse_cnt[m] <= 0;
            end
        end else begin
            cyc      <= cyc + 1;
            pwm_prev <= motor_pwm;
            if (motor_pwm[0] && !pwm_prev[0]) begin
                frame_seen <= frame_seen + 1;
            end
            for (int m = 0; m < 4; m++) begin
                width_done[m] <= pwm_prev[m] && !motor_pwm[m];
                if (motor_pwm[m]) begin
                    high_cnt[m] <= high_cnt[m] + 1;
                end else if (pwm_prev[m]) begin
                    meas[m]      <= high_cnt[m];
                    high_cnt[m]  <= 0;
                    pulse_cnt[m] <= pulse_cnt[m] + 1;
                end
            end
        end
    end

    // Branch, queue and mixer behavior at each clock
    always @(posedge sys_clk) begin : model_step
        int                 t;
        int                 r;
        int                 p;
        int                 y;
        int                 yaw_off;
        logic signed [15:0] yaw_err;
        if (!resetn) begin
            q_roll.delete();
            q_pitch.delete();
            q_yaw.delete();
            credit      = QUEUE_DEPTH;
            yaw_locked  = 1'b0;
            yaw_target  = '0;
            exp_overrun <= 1'b0;
            for (int m = 0; m < 4; m++) begin
                model_rate[m] = 0;
                exp_width[m] <= ESC_MIN_US;
            end
        end else begin
            // Pop slot, one cycle after each frame boundary
            if ((cyc != 0) && (cyc % FRAME_US == 0)) begin
                // Frame just started runs on the rates from the last pop
                for (int m = 0; m < 4; m++) begin
                    exp_width[m] <= ESC_MIN_US + 4 * model_rate[m];
                end
                if (q_roll.size() != 0) begin
                    t = rc_model[0];
                    r = q_roll.pop_front();
                    p = q_pitch.pop_front();
                    y = q_yaw.pop_front();
                    model_rate[0] = mix_clamp(t, t + p + r - y);
                    model_rate[1] = mix_clamp(t, t + p - r + y);
                    model_rate[2] = mix_clamp(t, t - p - r - y);
                    model_rate[3] = mix_clamp(t, t - p + r + y);
                    credit++;
                end
            end
            exp_overrun <= 1'b0;
            if (imu_valid) begin
                if (credit == 0) begin
                    exp_overrun <= 1'b1;
                end else begin
                    credit--;
                    q_roll.push_back(tilt_rate(rc_model[1], imu_roll));
                    q_pitch.push_back(tilt_rate(rc_model[2], imu_pitch));
                    yaw_off = rc_model[3] - STICK_CENTER;
                    if (!yaw_locked) begin
                        yaw_target = imu_heading;
                        yaw_locked = 1'b1;
                    end else if (yaw_off > YAW_DEADBAND || yaw_off < -YAW_DEADBAND) begin
                        yaw_target = yaw_target + 16'(yaw_off);
                    end
                    yaw_err = yaw_target - imu_heading;
                    q_yaw.push_back(int'(yaw_err >>> KP_SHIFT));
                end
            end
        end
    end

    for (genvar g = 0; g < 4; g++) begin : g_motor_chk
        a_width: assert property (@(posedge sys_clk) disable iff (!resetn)
            width_done[g] |-> (meas[g] == exp_width[g]))
            else begin
                mismatches++;
                $display("mismatch motor_%0d_pwm width: got 0x%0h expected 0x%0h",
                    g + 1, $sampled(meas[g]), $sampled(exp_width[g]));
            end

        // Nothing on the ESC lines before the first frame
        a_idle: assert property (@(posedge sys_clk) disable iff (!resetn)
            (cyc < FRAME_US) |-> (motor_pwm[g] == 1'b0))
            else begin
                failures++;
                $display("motor_%0d_pwm went high before the first frame start", g + 1);
            end
    end

    a_overrun: assert property (@(posedge sys_clk) disable iff (!resetn)
        imu_overrun == exp_overrun)
        else begin
            mismatches++;
            $display("mismatch imu_overrun: got 0x%0h expected 0x%0h",
                $sampled(imu_overrun), $sampled(exp_overrun));
        end

    task automatic finish_run;
        $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic wait_frame;
        int start;
        int waited;
        start  = frame_seen;
        waited = 0;
        while (frame_seen == start && waited < 2 * FRAME_US) begin
            @(posedge sys_clk);
            waited++;
        end
        if (frame_seen == start) begin
            failures++;
            $display("Timeout: no motor frame start within %0d cycles", 2 * FRAME_US);
            finish_run();
        end
    endtask

    // Two full receiver periods so every decoder holds the new value
    task automatic settle_sticks;
        int start;
        int waited;
        start  = rc_periods;
        waited = 0;
        while (rc_periods < start + 2 && waited < 3 * RC_PERIOD) begin
            @(posedge sys_clk);
            waited++;
        end
        if (rc_periods < start + 2) begin
            failures++;
            $display("Timeout: receiver pulses stalled");
            finish_run();
        end
    endtask

    task automatic set_sticks(input int thr, input int roll, input int pitch, input int yaw);
        int w [4];
        w[0] = thr;
        w[1] = roll;
        w[2] = pitch;
        w[3] = yaw;
        @(posedge sys_clk);
        for (int ch = 0; ch < 4; ch++) begin
            rc_width[ch] <= w[ch];
            rc_model[ch] <= rc_decode(w[ch]);
        end
    endtask

    task automatic imu_strobe(input int roll_ang, input int pitch_ang, input int heading);
        @(posedge sys_clk);
        imu_valid   <= 1'b1;
        imu_roll    <= 16'(roll_ang);
        imu_pitch   <= 16'(pitch_ang);
        imu_heading <= 16'(heading);
        @(posedge sys_clk);
        imu_valid <= 1'b0;
    endtask

    // Strobe early in a frame, popped at the next, shown in the one after
    task automatic strobe_one_frame(input int roll_ang, input int pitch_ang, input int heading);
        wait_frame();
        repeat (10) @(posedge sys_clk);
        imu_strobe(roll_ang, pitch_ang, heading);
        wait_frame();
        wait_frame();
    endtask

    initial begin
        void'($urandom(SEED));
        repeat (4) @(posedge sys_clk);
        resetn <= 1'b1;

        // Disarmed, throttle decodes to 5
        set_sticks(1020, 1500, 1500, 1500);
        settle_sticks();
        strobe_one_frame(0, 0, 0);
        strobe_one_frame(0, 0, 0);

        // Throttle only
        for (int i = 0; i < 6; i++) begin
            set_sticks(1100 + int'($urandom_range(900)), 1500, 1500, 1500);
            settle_sticks();
            strobe_one_frame(0, 0, 0);
        end

        // Roll and pitch spread wide enough to hit both clamps
        for (int i = 0; i < 10; i++) begin
            set_sticks(1100 + int'($urandom_range(900)), 1000 + int'($urandom_range(1000)),
                1000 + int'($urandom_range(1000)), 1500);
            settle_sticks();
            strobe_one_frame(rand_angle(600), rand_angle(600), 0);
        end

        // Yaw inside the deadband, offset +5
        set_sticks(1500, 1500, 1500, 1520);
        settle_sticks();
        strobe_one_frame(0, 0, rand_angle(200));
        strobe_one_frame(0, 0, rand_angle(200));
        // Outside, offset +25 then -25
        set_sticks(1500, 1500, 1500, 1600);
        settle_sticks();
        repeat (3) strobe_one_frame(0, 0, rand_angle(200));
        set_sticks(1500, 1500, 1500, 1400);
        settle_sticks();
        repeat (3) strobe_one_frame(0, 0, rand_angle(200));

        // Three strobes in one frame, third one has no credit
        set_sticks(1500, 1500, 1500, 1500);
        settle_sticks();
        wait_frame();
        repeat (10) @(posedge sys_clk);
        imu_strobe(40, -40, 0);
        imu_strobe(-80, 80, 0);
        imu_strobe(200, 200, 0);
        repeat (4) wait_frame();

        for (int m = 0; m < 4; m++) begin
            assert (pulse_cnt[m] + 1 >= frame_seen)
                else begin
                    failures++;
                    $display("motor_%0d_pwm gave %0d pulses over %0d frames",
                        m + 1, pulse_cnt[m], frame_seen);
                end
        end
        finish_run();
    end

endmodule

`default_nettype wire
